/* common/id_pkg.sv */
package id_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int LINK_REG   = 31;
    localparam int IMM_W      = 16;  // i-type immediate field
    localparam int JUMP_IDX_W = 26;  // j-type index field

    // primary opcodes, inst[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    // function codes under OP_SPECIAL, inst[5:0]
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_JALR = 6'b001001;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALUOP_NOP, ALUOP_AND, ALUOP_OR, ALUOP_XOR, ALUOP_NOR,
        ALUOP_SLL, ALUOP_SRL, ALUOP_SRA, ALUOP_JR, ALUOP_JALR
    } aluop_e;

    typedef enum logic [2:0] {
        ALUSEL_NOP, ALUSEL_LOGIC, ALUSEL_SHIFT, ALUSEL_JUMP
    } alusel_e;

    typedef struct packed {
        aluop_e                  aluop;
        alusel_e                 alusel;
        logic                    re1;
        logic                    re2;
        reg_addr_t               raddr1;
        reg_addr_t               raddr2;
        logic                    we;
        reg_addr_t               waddr;
        word_t                   imm;
        logic                    is_jump;
        logic                    jump_reg;    // target taken from operand 1
        logic                    link;        // writes the return address
        logic [JUMP_IDX_W-1:0]   jump_index;
        logic                    illegal;
    } dec_ctrl_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } fwd_t;

    typedef struct packed {
        aluop_e    aluop;
        alusel_e   alusel;
        word_t     op1;
        word_t     op2;
        logic      we;
        reg_addr_t waddr;
        word_t     return_addr;
        logic      illegal;
    } ex_bundle_t;

    typedef struct packed {
        word_t target;
    } redirect_t;

endpackage

/* decode/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  id_pkg::word_t     inst_i,
    output id_pkg::dec_ctrl_t ctrl_o
);

    logic [5:0]              op;
    id_pkg::reg_addr_t       rs;
    id_pkg::reg_addr_t       rt;
    id_pkg::reg_addr_t       rd;
    logic [4:0]              sa;
    logic [5:0]              funct;
    logic [id_pkg::IMM_W-1:0] imm16;

    logic legal;
    logic rr_op;  // rd <- rs op rt
    logic sh_op;  // rd <- rt shifted by sa

    assign op    = inst_i[31:26];
    assign rs    = inst_i[25:21];
    assign rt    = inst_i[20:16];
    assign rd    = inst_i[15:11];
    assign sa    = inst_i[10:6];
    assign funct = inst_i[5:0];
    assign imm16 = inst_i[15:0];

    always_comb begin
        // r-type defaults
        ctrl_o            = '0;
        ctrl_o.aluop      = id_pkg::ALUOP_NOP;
        ctrl_o.alusel     = id_pkg::ALUSEL_NOP;
        ctrl_o.raddr1     = rs;
        ctrl_o.raddr2     = rt;
        ctrl_o.waddr      = rd;
        ctrl_o.jump_index = inst_i[id_pkg::JUMP_IDX_W-1:0];
        legal             = 1'b0;
        rr_op             = 1'b0;
        sh_op             = 1'b0;

        case (op)
            id_pkg::OP_SPECIAL: begin
                case (funct)
                    id_pkg::FN_AND: begin
                        ctrl_o.aluop  = id_pkg::ALUOP_AND;
                        ctrl_o.alusel = id_pkg::ALUSEL_LOGIC;
                        rr_op         = 1'b1;
                    end
                    id_pkg::FN_OR: begin
                        ctrl_o.aluop  = id_pkg::ALUOP_OR;
                        ctrl_o.alusel = id_pkg::ALUSEL_LOGIC;
                        rr_op         = 1'b1;
                    end
                    id_pkg::FN_XOR: begin
                        ctrl_o.aluop  = id_pkg::ALUOP_XOR;
                        ctrl_o.alusel = id_pkg::ALUSEL_LOGIC;
                        rr_op         = 1'b1;
                    end
                    id_pkg::FN_NOR: begin
                        ctrl_o.aluop  = id_pkg::ALUOP_NOR;
                        ctrl_o.alusel = id_pkg::ALUSEL_LOGIC;
                        rr_op         = 1'b1;
                    end
                    id_pkg::FN_SLLV, id_pkg::FN_SLL: begin
                        ctrl_o.aluop  = id_pkg::ALUOP_SLL;
                        ctrl_o.alusel = id_pkg::ALUSEL_SHIFT;
                        rr_op         = (funct == id_pkg::FN_SLLV);
                        sh_op         = (funct == id_pkg::FN_SLL);
                    end
                    id_pkg::FN_SRLV, id_pkg::FN_SRL: begin
                        ctrl_o.aluop  = id_pkg::ALUOP_SRL;
                        ctrl_o.alusel = id_pkg::ALUSEL_SHIFT;
                        rr_op         = (funct == id_pkg::FN_SRLV);
                        sh_op         = (funct == id_pkg::FN_SRL);
                    end
                    id_pkg::FN_SRAV, id_pkg::FN_SRA: begin
                        ctrl_o.aluop  = id_pkg::ALUOP_SRA;
                        ctrl_o.alusel = id_pkg::ALUSEL_SHIFT;
                        rr_op         = (funct == id_pkg::FN_SRAV);
                        sh_op         = (funct == id_pkg::FN_SRA);
                    end
                    id_pkg::FN_JR, id_pkg::FN_JALR: begin
                        ctrl_o.aluop    = (funct == id_pkg::FN_JR) ? id_pkg::ALUOP_JR
                                                                   : id_pkg::ALUOP_JALR;
                        ctrl_o.alusel   = id_pkg::ALUSEL_JUMP;
                        ctrl_o.re1      = 1'b1;  // target in rs
                        ctrl_o.is_jump  = 1'b1;
                        ctrl_o.jump_reg = 1'b1;
                        ctrl_o.link     = (funct == id_pkg::FN_JALR);
                        ctrl_o.we       = (funct == id_pkg::FN_JALR);
                        legal           = (sa == '0);
                    end
                    default: ;
                endcase
                if (rr_op && sa == '0) begin
                    ctrl_o.re1 = 1'b1;
                    ctrl_o.re2 = 1'b1;
                    ctrl_o.we  = 1'b1;
                    legal      = 1'b1;
                end
                if (sh_op && rs == '0) begin
                    ctrl_o.re1    = 1'b1;
                    ctrl_o.raddr1 = rt;  // shifted value comes from rt
                    ctrl_o.imm    = {{(id_pkg::XLEN-5){1'b0}}, sa};
                    ctrl_o.we     = 1'b1;
                    legal         = 1'b1;
                end
            end
            id_pkg::OP_ORI, id_pkg::OP_ANDI, id_pkg::OP_XORI: begin
                ctrl_o.aluop  = (op == id_pkg::OP_ORI)  ? id_pkg::ALUOP_OR  :
                                (op == id_pkg::OP_ANDI) ? id_pkg::ALUOP_AND :
                                                          id_pkg::ALUOP_XOR;
                ctrl_o.alusel = id_pkg::ALUSEL_LOGIC;
                ctrl_o.re1    = 1'b1;
                ctrl_o.imm    = {{(id_pkg::XLEN-id_pkg::IMM_W){1'b0}}, imm16};
                ctrl_o.we     = 1'b1;
                ctrl_o.waddr  = rt;
                legal         = 1'b1;
            end
            id_pkg::OP_LUI: begin
                ctrl_o.aluop  = id_pkg::ALUOP_OR;  // imm | imm
                ctrl_o.alusel = id_pkg::ALUSEL_LOGIC;
                ctrl_o.imm    = {imm16, {(id_pkg::XLEN-id_pkg::IMM_W){1'b0}}};
                ctrl_o.we     = 1'b1;
                ctrl_o.waddr  = rt;
                legal         = 1'b1;
            end
            id_pkg::OP_J, id_pkg::OP_JAL: begin
                ctrl_o.aluop   = (op == id_pkg::OP_J) ? id_pkg::ALUOP_JR : id_pkg::ALUOP_JALR;
                ctrl_o.alusel  = id_pkg::ALUSEL_JUMP;
                ctrl_o.is_jump = 1'b1;
                ctrl_o.link    = (op == id_pkg::OP_JAL);
                ctrl_o.we      = (op == id_pkg::OP_JAL);  // link reg picked later
                legal          = 1'b1;
            end
            default: ;
        endcase

        // unknown encoding, squash every side effect
        if (!legal) begin
            ctrl_o.aluop    = id_pkg::ALUOP_NOP;
            ctrl_o.alusel   = id_pkg::ALUSEL_NOP;
            ctrl_o.re1      = 1'b0;
            ctrl_o.re2      = 1'b0;
            ctrl_o.we       = 1'b0;
            ctrl_o.is_jump  = 1'b0;
            ctrl_o.jump_reg = 1'b0;
            ctrl_o.link     = 1'b0;
        end
        ctrl_o.illegal = !legal;
    end

    illegal_no_write_a: assert final (!(ctrl_o.illegal && ctrl_o.we));

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              we_i,
    input  id_pkg::reg_addr_t waddr_i,
    input  id_pkg::word_t     wdata_i,
    input  id_pkg::reg_addr_t raddr1_i,
    input  id_pkg::reg_addr_t raddr2_i,
    output id_pkg::word_t     rdata1_o,
    output id_pkg::word_t     rdata2_o
);

    id_pkg::word_t regs [id_pkg::NUM_REGS];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < id_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin  // $0 is hardwired
            regs[waddr_i] <= wdata_i;
        end
    end

    // old value on a same-cycle write, mem forward covers it
    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

    zero_reg_stable_a: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (we_i && waddr_i == '0) |=> $stable(regs[0])
    );

endmodule

/* src/operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass (
    input  logic              re_i,
    input  id_pkg::reg_addr_t raddr_i,
    input  id_pkg::word_t     rf_data_i,
    input  id_pkg::word_t     imm_i,
    input  id_pkg::fwd_t      ex_fwd_i,
    input  id_pkg::fwd_t      mem_fwd_i,
    output id_pkg::word_t     operand_o
);

    logic ex_hit;
    logic mem_hit;

    // a forward to $0 never matches
    assign ex_hit  = ex_fwd_i.we && ex_fwd_i.waddr == raddr_i && ex_fwd_i.waddr != '0;
    assign mem_hit = mem_fwd_i.we && mem_fwd_i.waddr == raddr_i && mem_fwd_i.waddr != '0;

    always_comb begin
        if (!re_i) begin
            operand_o = imm_i;
        end else if (ex_hit) begin  // youngest result wins
            operand_o = ex_fwd_i.wdata;
        end else if (mem_hit) begin
            operand_o = mem_fwd_i.wdata;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

/* src/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit (
    input  id_pkg::dec_ctrl_t ctrl_i,
    input  id_pkg::word_t     pc_i,
    input  id_pkg::word_t     op1_i,
    output id_pkg::redirect_t target_o,
    output id_pkg::word_t     return_addr_o,
    output id_pkg::reg_addr_t waddr_o
);

    logic use_link_reg;

    // pc is word addressed, skip the next slot
    assign return_addr_o = pc_i + id_pkg::word_t'(2);

    assign target_o.target = ctrl_i.jump_reg ? op1_i
                           : {{(id_pkg::XLEN-id_pkg::JUMP_IDX_W){1'b0}}, ctrl_i.jump_index};

    // jal always, jalr only when rd is $0
    assign use_link_reg = ctrl_i.link && !(ctrl_i.jump_reg && ctrl_i.waddr != '0);

    assign waddr_o = use_link_reg ? id_pkg::reg_addr_t'(id_pkg::LINK_REG) : ctrl_i.waddr;

endmodule

/* src/stage_reg.sv */
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;  // one pulse per strobe
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            data_o <= data_i;  // held while idle
        end
    end

    pulse_per_strobe_a: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (valid_o && $past(valid_o)) |-> ($past(valid_i) && $past(valid_i, 2))
    );

endmodule

/* src/id_stage.sv */
`timescale 1ns/1ps

module id_stage (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               inst_valid_i,
    input  id_pkg::word_t      pc_i,
    input  id_pkg::word_t      inst_i,
    input  id_pkg::fwd_t       ex_fwd_i,
    input  id_pkg::fwd_t       mem_fwd_i,
    input  logic               wb_valid_i,
    input  id_pkg::reg_addr_t  wb_waddr_i,
    input  id_pkg::word_t      wb_wdata_i,
    output logic               ex_valid_o,
    output id_pkg::ex_bundle_t ex_bundle_o,
    output logic               redirect_valid_o,
    output id_pkg::redirect_t  redirect_o
);

    id_pkg::dec_ctrl_t  ctrl;
    id_pkg::word_t      rf_rdata1;
    id_pkg::word_t      rf_rdata2;
    id_pkg::word_t      op1;
    id_pkg::word_t      op2;
    id_pkg::redirect_t  target;
    id_pkg::word_t      return_addr;
    id_pkg::reg_addr_t  waddr;
    id_pkg::ex_bundle_t bundle_d;
    logic               redirect_valid_d;

    inst_decoder u_decoder (
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    reg_file u_reg_file (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .we_i     (wb_valid_i),
        .waddr_i  (wb_waddr_i),
        .wdata_i  (wb_wdata_i),
        .raddr1_i (ctrl.raddr1),
        .raddr2_i (ctrl.raddr2),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    operand_bypass u_bypass1 (
        .re_i      (ctrl.re1),
        .raddr_i   (ctrl.raddr1),
        .rf_data_i (rf_rdata1),
        .imm_i     (ctrl.imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (op1)
    );

    operand_bypass u_bypass2 (
        .re_i      (ctrl.re2),
        .raddr_i   (ctrl.raddr2),
        .rf_data_i (rf_rdata2),
        .imm_i     (ctrl.imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (op2)
    );

    branch_unit u_branch (
        .ctrl_i        (ctrl),
        .pc_i          (pc_i),
        .op1_i         (op1),      // jr target, already forwarded
        .target_o      (target),
        .return_addr_o (return_addr),
        .waddr_o       (waddr)
    );

    assign bundle_d.aluop       = ctrl.aluop;
    assign bundle_d.alusel      = ctrl.alusel;
    assign bundle_d.op1         = op1;
    assign bundle_d.op2         = op2;
    assign bundle_d.we          = ctrl.we;
    assign bundle_d.waddr       = waddr;
    assign bundle_d.return_addr = return_addr;
    assign bundle_d.illegal     = ctrl.illegal;

    assign redirect_valid_d = inst_valid_i && ctrl.is_jump;

    stage_reg #(.payload_t(id_pkg::ex_bundle_t)) u_ex_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (inst_valid_i),
        .data_i  (bundle_d),
        .valid_o (ex_valid_o),
        .data_o  (ex_bundle_o)
    );

    stage_reg #(.payload_t(id_pkg::redirect_t)) u_redirect_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (redirect_valid_d),
        .data_i  (target),
        .valid_o (redirect_valid_o),
        .data_o  (redirect_o)
    );

endmodule

/* testbench/tb_id_stage.sv */
`timescale 1ns/1ps

module tb_id_stage;

    localparam int NUM_TESTS = 6;
    localparam int CLK_PERIOD = 10;

    typedef struct {
        id_pkg::ex_bundle_t b;
        logic               chk_op1;
        logic               chk_op2;
        logic               chk_ret;
        logic               redir;
        id_pkg::word_t      target;
        int                 due;  // monitor cycle of the expected bundle
    } expect_t;

    logic               clk_i = 1'b0;
    logic               rst_n_i;
    logic               inst_valid_i;
    id_pkg::word_t      pc_i;
    id_pkg::word_t      inst_i;
    id_pkg::fwd_t       ex_fwd_i;
    id_pkg::fwd_t       mem_fwd_i;
    logic               wb_valid_i;
    id_pkg::reg_addr_t  wb_waddr_i;
    id_pkg::word_t      wb_wdata_i;
    logic               ex_valid_o;
    id_pkg::ex_bundle_t ex_bundle_o;
    logic               redirect_valid_o;
    id_pkg::redirect_t  redirect_o;

    id_pkg::word_t shadow [id_pkg::NUM_REGS];  // register file as the tb expects it
    expect_t       expect_q [$];
    logic [31:0]   lfsr = 32'hcf79;
    int            cycle_cnt = 0;
    int            errors = 0;

    id_stage u_dut (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic id_pkg::word_t rand_bits(input int n);
        id_pkg::word_t v;
        logic          fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic id_pkg::word_t r_type(input int rs, input int rt, input int rd,
                                             input int sa, input logic [5:0] fn);
        return {6'b000000, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
    endfunction

    function automatic id_pkg::word_t i_type(input logic [5:0] op, input int rs, input int rt,
                                             input id_pkg::word_t imm);
        return {op, 5'(rs), 5'(rt), imm[15:0]};
    endfunction

    function automatic id_pkg::fwd_t fwd_to(input int addr, input id_pkg::word_t data);
        id_pkg::fwd_t f;
        f.we    = 1'b1;
        f.waddr = 5'(addr);
        f.wdata = data;
        return f;
    endfunction

    // ex before mem before the register file
    function automatic id_pkg::word_t resolve(input id_pkg::reg_addr_t a,
                                              input id_pkg::fwd_t exf, input id_pkg::fwd_t mf);
        if (a == '0) return '0;
        if (exf.we && exf.waddr == a) return exf.wdata;
        if (mf.we && mf.waddr == a) return mf.wdata;
        return shadow[a];
    endfunction

    function automatic expect_t model(input id_pkg::word_t pc, input id_pkg::word_t inst,
                                      input id_pkg::fwd_t exf, input id_pkg::fwd_t mf);
        expect_t           e;
        logic [5:0]        op;
        logic [5:0]        fn;
        id_pkg::reg_addr_t rs;
        id_pkg::reg_addr_t rt;
        id_pkg::reg_addr_t rd;
        logic [4:0]        sa;
        logic              legal;
        op = inst[31:26];
        rs = inst[25:21];
        rt = inst[20:16];
        rd = inst[15:11];
        sa = inst[10:6];
        fn = inst[5:0];
        e.b = '0;
        e.chk_op1 = 1'b0;
        e.chk_op2 = 1'b0;
        e.chk_ret = 1'b0;
        e.redir = 1'b0;
        e.target = '0;
        e.due = cycle_cnt + 2;  // sampled next edge and seen on the negedge after
        e.b.return_addr = pc + 32'd2;
        legal = 1'b1;
        case (op)
            id_pkg::OP_SPECIAL: begin
                case (fn)
                    id_pkg::FN_AND: e.b.aluop = id_pkg::ALUOP_AND;
                    id_pkg::FN_OR: e.b.aluop = id_pkg::ALUOP_OR;
                    id_pkg::FN_XOR: e.b.aluop = id_pkg::ALUOP_XOR;
                    id_pkg::FN_NOR: e.b.aluop = id_pkg::ALUOP_NOR;
                    id_pkg::FN_SLL, id_pkg::FN_SLLV: e.b.aluop = id_pkg::ALUOP_SLL;
                    id_pkg::FN_SRL, id_pkg::FN_SRLV: e.b.aluop = id_pkg::ALUOP_SRL;
                    id_pkg::FN_SRA, id_pkg::FN_SRAV: e.b.aluop = id_pkg::ALUOP_SRA;
                    id_pkg::FN_JR: e.b.aluop = id_pkg::ALUOP_JR;
                    id_pkg::FN_JALR: e.b.aluop = id_pkg::ALUOP_JALR;
                    default: legal = 1'b0;
                endcase
                if (fn == id_pkg::FN_JR || fn == id_pkg::FN_JALR) begin
                    legal = legal && sa == 5'd0;
                    e.b.alusel = id_pkg::ALUSEL_JUMP;
                    e.b.op1 = resolve(rs, exf, mf);
                    e.chk_op1 = 1'b1;
                    e.redir = 1'b1;
                    e.target = e.b.op1;
                    if (fn == id_pkg::FN_JALR) begin
                        e.b.we = 1'b1;
                        e.b.waddr = (rd != '0) ? rd : 5'(id_pkg::LINK_REG);
                        e.chk_ret = 1'b1;
                    end
                end else if (fn == id_pkg::FN_SLL || fn == id_pkg::FN_SRL ||
                             fn == id_pkg::FN_SRA) begin
                    legal = legal && rs == '0;
                    e.b.alusel = id_pkg::ALUSEL_SHIFT;
                    e.b.op1 = resolve(rt, exf, mf);  // value to shift is rt
                    e.b.op2 = 32'(sa);
                    e.chk_op1 = 1'b1;
                    e.chk_op2 = 1'b1;
                    e.b.we = 1'b1;
                    e.b.waddr = rd;
                end else begin
                    legal = legal && sa == 5'd0;
                    e.b.alusel = (fn == id_pkg::FN_SLLV || fn == id_pkg::FN_SRLV ||
                                  fn == id_pkg::FN_SRAV) ? id_pkg::ALUSEL_SHIFT
                                                         : id_pkg::ALUSEL_LOGIC;
                    e.b.op1 = resolve(rs, exf, mf);
                    e.b.op2 = resolve(rt, exf, mf);
                    e.chk_op1 = 1'b1;
                    e.chk_op2 = 1'b1;
                    e.b.we = 1'b1;
                    e.b.waddr = rd;
                end
            end
            id_pkg::OP_ORI, id_pkg::OP_ANDI, id_pkg::OP_XORI: begin
                e.b.aluop = (op == id_pkg::OP_ORI) ? id_pkg::ALUOP_OR :
                            (op == id_pkg::OP_ANDI) ? id_pkg::ALUOP_AND : id_pkg::ALUOP_XOR;
                e.b.alusel = id_pkg::ALUSEL_LOGIC;
                e.b.op1 = resolve(rs, exf, mf);
                e.b.op2 = {16'h0000, inst[15:0]};
                e.chk_op1 = 1'b1;
                e.chk_op2 = 1'b1;
                e.b.we = 1'b1;
                e.b.waddr = rt;
            end
            id_pkg::OP_LUI: begin
                e.b.aluop = id_pkg::ALUOP_OR;
                e.b.alusel = id_pkg::ALUSEL_LOGIC;
                e.b.op2 = {inst[15:0], 16'h0000};
                e.chk_op2 = 1'b1;
                e.b.we = 1'b1;
                e.b.waddr = rt;
            end
            id_pkg::OP_J, id_pkg::OP_JAL: begin
                e.b.alusel = id_pkg::ALUSEL_JUMP;
                e.redir = 1'b1;
                e.target = {6'b000000, inst[25:0]};
                e.b.aluop = (op == id_pkg::OP_J) ? id_pkg::ALUOP_JR : id_pkg::ALUOP_JALR;
                if (op == id_pkg::OP_JAL) begin
                    e.b.we = 1'b1;
                    e.b.waddr = 5'(id_pkg::LINK_REG);
                    e.chk_ret = 1'b1;
                end
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            e.b.aluop = id_pkg::ALUOP_NOP;
            e.b.alusel = id_pkg::ALUSEL_NOP;
            e.b.we = 1'b0;
            e.redir = 1'b0;
            e.chk_op1 = 1'b0;
            e.chk_op2 = 1'b0;
            e.chk_ret = 1'b0;
        end
        e.b.illegal = !legal;
        return e;
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Error: %0t ns %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // checks every cycle including reset
    always @(negedge clk_i) begin : monitor
        expect_t e;
        logic    due_now;
        cycle_cnt++;
        due_now = 1'b0;
        if (expect_q.size() != 0) begin
            due_now = (expect_q[0].due == cycle_cnt);
        end
        compare("ex_valid_o", 32'(due_now), 32'(ex_valid_o));
        if (due_now) begin
            e = expect_q.pop_front();
            compare("redirect_valid_o", 32'(e.redir), 32'(redirect_valid_o));
            compare("ex_bundle_o.aluop", e.b.aluop, ex_bundle_o.aluop);
            compare("ex_bundle_o.alusel", e.b.alusel, ex_bundle_o.alusel);
            compare("ex_bundle_o.we", 32'(e.b.we), 32'(ex_bundle_o.we));
            compare("ex_bundle_o.illegal", 32'(e.b.illegal), 32'(ex_bundle_o.illegal));
            if (e.b.we) compare("ex_bundle_o.waddr", e.b.waddr, ex_bundle_o.waddr);
            if (e.chk_op1) compare("ex_bundle_o.op1", e.b.op1, ex_bundle_o.op1);
            if (e.chk_op2) compare("ex_bundle_o.op2", e.b.op2, ex_bundle_o.op2);
            if (e.chk_ret) compare("ex_bundle_o.return_addr", e.b.return_addr,
                                   ex_bundle_o.return_addr);
            if (e.redir) compare("redirect_o.target", e.target, redirect_o.target);
        end else begin
            compare("redirect_valid_o", 32'd0, 32'(redirect_valid_o));
        end
    end

    task automatic send(input id_pkg::word_t pc, input id_pkg::word_t inst,
                        input id_pkg::fwd_t exf, input id_pkg::fwd_t mf);
        @(posedge clk_i);
        inst_valid_i <= 1'b1;
        pc_i         <= pc;
        inst_i       <= inst;
        ex_fwd_i     <= exf;
        mem_fwd_i    <= mf;
        expect_q.push_back(model(pc, inst, exf, mf));
    endtask

    task automatic drive_wb(input int addr, input id_pkg::word_t data);
        wb_valid_i <= 1'b1;
        wb_waddr_i <= 5'(addr);
        wb_wdata_i <= data;
        if (addr != 0) shadow[addr] = data;  // committed on the next edge
    endtask

    task automatic idle();
        @(posedge clk_i);
        inst_valid_i <= 1'b0;
        ex_fwd_i     <= '0;
        mem_fwd_i    <= '0;
        wb_valid_i   <= 1'b0;
    endtask

    task automatic drain();
        while (expect_q.size() != 0) @(posedge clk_i);
    endtask

    task automatic write_reg(input int addr, input id_pkg::word_t data);
        @(posedge clk_i);
        drive_wb(addr, data);
        idle();
    endtask

    task automatic issue(input id_pkg::word_t inst, input id_pkg::fwd_t exf,
                         input id_pkg::fwd_t mf);
        send(rand_bits(32), inst, exf, mf);
        idle();
        drain();
    endtask

    task automatic test_reset_values();
        for (int i = 0; i < 16; i++) issue(r_type(i, i + 16, 1, 0, id_pkg::FN_OR), '0, '0);
    endtask

    task automatic test_rtype();
        logic [5:0] fns [7] = '{id_pkg::FN_AND, id_pkg::FN_OR, id_pkg::FN_XOR, id_pkg::FN_NOR,
                               id_pkg::FN_SLLV, id_pkg::FN_SRLV, id_pkg::FN_SRAV};
        for (int i = 1; i < id_pkg::NUM_REGS; i++) write_reg(i, rand_bits(32));
        foreach (fns[i]) issue(r_type(rand_bits(5), rand_bits(5), rand_bits(5), 0, fns[i]),
                               '0, '0);
        issue(r_type(0, rand_bits(5), rand_bits(5), rand_bits(5), id_pkg::FN_SLL), '0, '0);
        issue(r_type(0, rand_bits(5), rand_bits(5), rand_bits(5), id_pkg::FN_SRL), '0, '0);
        issue(r_type(0, rand_bits(5), rand_bits(5), rand_bits(5), id_pkg::FN_SRA), '0, '0);
    endtask

    task automatic test_immediates();
        issue(i_type(id_pkg::OP_ORI, rand_bits(5), rand_bits(5), rand_bits(16)), '0, '0);
        issue(i_type(id_pkg::OP_ANDI, rand_bits(5), rand_bits(5), rand_bits(16)), '0, '0);
        issue(i_type(id_pkg::OP_XORI, rand_bits(5), rand_bits(5), rand_bits(16)), '0, '0);
        issue(i_type(id_pkg::OP_LUI, 0, rand_bits(5), rand_bits(16)), '0, '0);
    endtask

    task automatic test_forwarding();
        issue(r_type(3, 5, 9, 0, id_pkg::FN_XOR), fwd_to(3, rand_bits(32)),
              fwd_to(3, rand_bits(32)));
        issue(r_type(3, 5, 9, 0, id_pkg::FN_XOR), fwd_to(5, rand_bits(32)),
              fwd_to(5, rand_bits(32)));
        issue(r_type(3, 5, 9, 0, id_pkg::FN_AND), '0, fwd_to(3, rand_bits(32)));
        issue(r_type(3, 5, 9, 0, id_pkg::FN_AND), '0, fwd_to(5, rand_bits(32)));
        issue(r_type(0, 0, 9, 0, id_pkg::FN_OR), fwd_to(0, rand_bits(32)),
              fwd_to(0, rand_bits(32)));
        // writeback racing the read leaves the old value
        send(rand_bits(32), r_type(3, 5, 9, 0, id_pkg::FN_OR), '0, '0);
        drive_wb(3, rand_bits(32));
        idle();
        drain();
        issue(r_type(3, 5, 9, 0, id_pkg::FN_OR), '0, '0);
    endtask

    task automatic test_jumps();
        issue({id_pkg::OP_J, 26'(rand_bits(26))}, '0, '0);
        issue({id_pkg::OP_JAL, 26'(rand_bits(26))}, '0, '0);
        issue(r_type(4, 0, 0, 0, id_pkg::FN_JR), fwd_to(4, rand_bits(32)), '0);
        issue(r_type(4, 0, 0, 0, id_pkg::FN_JALR), '0, fwd_to(4, rand_bits(32)));
        issue(r_type(6, 0, 7, 0, id_pkg::FN_JALR), '0, '0);
    endtask

    task automatic test_illegal();
        issue(i_type(6'b111111, rand_bits(5), rand_bits(5), rand_bits(16)), '0, '0);
        issue(r_type(1, 2, 3, 0, 6'b100000), '0, '0);  // add is not decoded
        // one bundle per strobe in issue order
        send(rand_bits(32), {id_pkg::OP_J, 26'(rand_bits(26))}, '0, '0);
        send(rand_bits(32), r_type(1, 2, 3, 0, id_pkg::FN_NOR), '0, '0);
        send(rand_bits(32), i_type(6'b000100, 1, 2, rand_bits(16)), '0, '0);
        send(rand_bits(32), {id_pkg::OP_JAL, 26'(rand_bits(26))}, '0, '0);
        idle();
        drain();
    endtask

    initial begin
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        pc_i         = '0;
        inst_i       = '0;
        ex_fwd_i     = '0;
        mem_fwd_i    = '0;
        wb_valid_i   = 1'b0;
        wb_waddr_i   = '0;
        wb_wdata_i   = '0;
        foreach (shadow[i]) shadow[i] = '0;
        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;
        test_reset_values();
        test_rtype();
        test_immediates();
        test_forwarding();
        test_jumps();
        test_illegal();
        repeat (2) @(posedge clk_i);
        $display("run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("watchdog expired, tests did not finish within %0d cycles", NUM_TESTS * 200);
        $display("Test failed");
        $finish;
    end

endmodule

/* vlog.f */
common/id_pkg.sv
decode/inst_decoder.sv
src/reg_file.sv
src/operand_bypass.sv
src/branch_unit.sv
src/stage_reg.sv
src/id_stage.sv
testbench/tb_id_stage.sv
